// File: common/ex_pkg.sv
package ex_pkg;

    localparam int XLEN = 64;
    localparam int HALF = 32;   // width of the W forms

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [5:0]      shamt_t;
    typedef logic [3:0]      funct_t;

    typedef enum logic [2:0] {
        OP_REG    = 3'd0,
        OP_IMM    = 3'd1,
        OP_BRANCH = 3'd2,
        OP_DIV    = 3'd3,
        OP_JAL    = 3'd4,
        OP_JALR   = 3'd5,
        OP_LUI    = 3'd6,
        OP_AUIPC  = 3'd7
    } ex_opcode_e;

    // funct3 in the low bits, bit 3 is funct7[5]
    typedef enum logic [3:0] {
        FN_ADD  = 4'd0,
        FN_SUB  = 4'd8,
        FN_SLL  = 4'd1,
        FN_SLT  = 4'd2,
        FN_SLTU = 4'd3,
        FN_XOR  = 4'd4,
        FN_SRL  = 4'd5,
        FN_SRA  = 4'd13,
        FN_OR   = 4'd6,
        FN_AND  = 4'd7
    } alu_fn_e;

    typedef enum logic [3:0] {
        BR_EQ  = 4'd0,
        BR_NE  = 4'd1,
        BR_LT  = 4'd4,
        BR_GE  = 4'd5,
        BR_LTU = 4'd6,
        BR_GEU = 4'd7
    } br_fn_e;

    typedef enum logic [3:0] {
        DV_DIV  = 4'd4,
        DV_DIVU = 4'd5,
        DV_REM  = 4'd6,
        DV_REMU = 4'd7
    } div_fn_e;

    typedef struct packed {
        ex_opcode_e opcode;
        funct_t     funct;
        logic       trunc;
    } ex_op_t;

    typedef struct packed {
        xlen_t dividend;
        xlen_t divisor;
        logic  is_signed;
        logic  want_rem;
        logic  trunc;
    } div_cmd_t;

    function automatic xlen_t sext_half(xlen_t v);
        return {{HALF{v[HALF-1]}}, v[HALF-1:0]};
    endfunction

endpackage

// File: alu/int_alu.sv
`timescale 1ns/1ps

module int_alu import ex_pkg::*; (
    input  ex_op_t op_i,
    input  xlen_t  rs1_i,
    input  xlen_t  rs2_i,
    input  xlen_t  imm_i,
    output xlen_t  alu_res_o
);

    alu_fn_e              fn;
    xlen_t                src_b;
    xlen_t                op_a;
    xlen_t                op_b;
    logic                 is_sub;
    xlen_t                sum;
    logic                 top_diff;
    logic                 lt_s;
    logic                 lt_u;
    shamt_t               shamt;
    xlen_t                sh_src;
    xlen_t                sh_rev;
    xlen_t                sh_in;
    logic                 sh_fill;
    logic signed [XLEN:0] sh_wide;
    xlen_t                sh_out;
    xlen_t                sh_back;
    xlen_t                sh_res;
    xlen_t                res;

    assign fn    = alu_fn_e'(op_i.funct);
    assign src_b = (op_i.opcode == OP_IMM) ? imm_i : rs2_i; // imm replaces rs2
    assign op_a  = op_i.trunc ? sext_half(rs1_i) : rs1_i;
    assign op_b  = op_i.trunc ? sext_half(src_b) : src_b;

    // shared adder for add, sub and both compares
    assign is_sub = (fn == FN_SUB) || (fn == FN_SLT) || (fn == FN_SLTU);
    assign sum    = op_a + (is_sub ? ~op_b : op_b) + xlen_t'(is_sub);

    // differing top bits settle the compare without the adder
    assign top_diff = op_a[XLEN-1] ^ op_b[XLEN-1];
    assign lt_s     = top_diff ? op_a[XLEN-1] : sum[XLEN-1];
    assign lt_u     = top_diff ? op_b[XLEN-1] : sum[XLEN-1];

    // single right shifter, left shift runs on the bit-reversed word
    assign shamt   = op_i.trunc ? {1'b0, op_b[4:0]} : op_b[5:0];
    assign sh_src  = (op_i.trunc && fn == FN_SRL) ? {{HALF{1'b0}}, op_a[HALF-1:0]} : op_a;
    assign sh_rev  = {<<{sh_src}};
    assign sh_in   = (fn == FN_SLL) ? sh_rev : sh_src;
    assign sh_fill = (fn == FN_SRA) & sh_in[XLEN-1];
    assign sh_wide = $signed({sh_fill, sh_in}) >>> shamt;
    assign sh_out  = sh_wide[XLEN-1:0];
    assign sh_back = {<<{sh_out}};
    assign sh_res  = (fn == FN_SLL) ? sh_back : sh_out;

    always_comb begin
        case (fn)
            FN_ADD, FN_SUB:         res = op_i.trunc ? sext_half(sum) : sum;
            FN_SLL, FN_SRL, FN_SRA: res = op_i.trunc ? sext_half(sh_res) : sh_res;
            FN_SLT:                 res = xlen_t'(lt_s);
            FN_SLTU:                res = xlen_t'(lt_u);
            FN_XOR:                 res = op_a ^ op_b;
            FN_OR:                  res = op_a | op_b;
            FN_AND:                 res = op_a & op_b;
            default:                res = '0;
        endcase
    end

    assign alu_res_o = (op_i.opcode == OP_LUI) ? imm_i : res;

endmodule

// File: alu/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import ex_pkg::*; (
    input  ex_op_t op_i,
    input  xlen_t  rs1_i,
    input  xlen_t  rs2_i,
    input  xlen_t  imm_i,
    input  xlen_t  pc_i,
    output logic   take_o,
    output xlen_t  target_o,
    output xlen_t  link_o
);

    br_fn_e fn;
    logic   eq;
    logic   lt_s;
    logic   lt_u;
    logic   cond;
    xlen_t  pc_off;
    xlen_t  reg_off;

    assign fn   = br_fn_e'(op_i.funct);
    assign eq   = (rs1_i == rs2_i);
    assign lt_s = $signed(rs1_i) < $signed(rs2_i);
    assign lt_u = rs1_i < rs2_i;

    always_comb begin
        case (fn)
            BR_EQ:   cond = eq;
            BR_NE:   cond = !eq;
            BR_LT:   cond = lt_s;
            BR_GE:   cond = !lt_s;
            BR_LTU:  cond = lt_u;
            BR_GEU:  cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        case (op_i.opcode)
            OP_BRANCH:        take_o = cond;
            OP_JAL, OP_JALR:  take_o = 1'b1;
            default:          take_o = 1'b0;
        endcase
    end

    assign pc_off   = pc_i + imm_i;
    assign reg_off  = rs1_i + imm_i;
    assign target_o = (op_i.opcode == OP_JALR) ? {reg_off[XLEN-1:1], 1'b0} : pc_off;
    assign link_o   = (op_i.opcode == OP_AUIPC) ? pc_off : pc_i + xlen_t'(4); // auipc reuses pc+imm

endmodule

// File: div/serial_divider.sv
`timescale 1ns/1ps

module serial_divider import ex_pkg::*; (
    input  logic     clk_sys_i,
    input  logic     arst_n_i,
    input  logic     div_req_i,
    input  div_cmd_t div_cmd_i,
    output logic     div_ack_o,
    output xlen_t    div_res_o
);

    typedef enum logic [2:0] {IDLE, LOAD, ITER, FIX, DONE} div_state_e;

    div_state_e                  state_q;
    logic [$clog2(XLEN)-1:0]     cnt_q;
    xlen_t                       a_ext;
    xlen_t                       b_ext;
    xlen_t                       min_neg;
    xlen_t                       dvd_q;
    xlen_t                       dvs_q;
    xlen_t                       quo_q;
    xlen_t                       rem_q;
    logic                        q_neg_q;
    logic                        r_neg_q;
    logic                        by_zero_q;
    logic                        ovf_q;
    logic                        want_rem_q;
    logic                        trunc_q;
    logic [XLEN:0]               trial;
    xlen_t                       quo_fix;
    xlen_t                       rem_fix;
    xlen_t                       pick;

    function automatic xlen_t ext_op(xlen_t v, logic trunc, logic sgn);
        if (!trunc) return v;
        return sgn ? sext_half(v) : {{HALF{1'b0}}, v[HALF-1:0]};
    endfunction

    function automatic xlen_t mag(xlen_t v, logic sgn);
        return (sgn && v[XLEN-1]) ? -v : v;
    endfunction

    assign a_ext   = ext_op(div_cmd_i.dividend, div_cmd_i.trunc, div_cmd_i.is_signed);
    assign b_ext   = ext_op(div_cmd_i.divisor, div_cmd_i.trunc, div_cmd_i.is_signed);
    assign min_neg = div_cmd_i.trunc ? {{(HALF+1){1'b1}}, {(HALF-1){1'b0}}}
                                     : {1'b1, {(XLEN-1){1'b0}}};

    assign trial   = {rem_q, quo_q[XLEN-1]} - {1'b0, dvs_q}; // msb set means borrow
    assign quo_fix = by_zero_q ? '1 : ovf_q ? dvd_q : q_neg_q ? -quo_q : quo_q;
    assign rem_fix = by_zero_q ? dvd_q : ovf_q ? '0 : r_neg_q ? -rem_q : rem_q;
    assign pick    = want_rem_q ? rem_fix : quo_fix;

    always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= IDLE;
            cnt_q     <= '0;
            div_ack_o <= 1'b0;
        end else begin
            case (state_q)
                IDLE: if (div_req_i) state_q <= LOAD;
                LOAD: begin // first restoring step
                    cnt_q   <= 1;
                    state_q <= ITER;
                end
                ITER: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == XLEN-1) state_q <= FIX;
                end
                FIX: begin
                    div_ack_o <= 1'b1;
                    state_q   <= DONE;
                end
                DONE: if (!div_req_i) begin
                    div_ack_o <= 1'b0;
                    state_q   <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_sys_i) begin
        if (state_q == IDLE && div_req_i) begin
            dvd_q      <= a_ext;
            dvs_q      <= mag(b_ext, div_cmd_i.is_signed);
            quo_q      <= mag(a_ext, div_cmd_i.is_signed);
            rem_q      <= '0;
            q_neg_q    <= div_cmd_i.is_signed & (a_ext[XLEN-1] ^ b_ext[XLEN-1]);
            r_neg_q    <= div_cmd_i.is_signed & a_ext[XLEN-1]; // remainder takes dividend sign
            by_zero_q  <= (b_ext == '0);
            ovf_q      <= div_cmd_i.is_signed && (a_ext == min_neg) && (b_ext == '1);
            want_rem_q <= div_cmd_i.want_rem;
            trunc_q    <= div_cmd_i.trunc;
        end else if (state_q == LOAD || state_q == ITER) begin
            if (!trial[XLEN]) begin
                rem_q <= trial[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= {rem_q[XLEN-2:0], quo_q[XLEN-1]};
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
        if (state_q == FIX) begin
            div_res_o <= trunc_q ? sext_half(pick) : pick;
        end
    end

    res_stable_a: assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
        div_ack_o && $past(div_ack_o) |-> $stable(div_res_o));

    ack_needs_req_a: assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
        $rose(div_ack_o) |-> div_req_i);

endmodule

// File: rtl/ex_ctrl.sv
`timescale 1ns/1ps

module ex_ctrl import ex_pkg::*; (
    input  logic     clk_sys_i,
    input  logic     arst_n_i,
    input  logic     issue_valid_i,
    input  ex_op_t   op_i,
    input  xlen_t    rs1_i,
    input  xlen_t    rs2_i,
    input  xlen_t    alu_res_i,
    input  xlen_t    link_i,
    input  xlen_t    target_i,
    input  logic     take_i,
    output logic     div_req_o,
    output div_cmd_t div_cmd_o,
    input  logic     div_ack_i,
    input  xlen_t    div_res_i,
    output logic     busy_o,
    output logic     result_valid_o,
    output xlen_t    result_o,
    output logic     jump_o,
    output xlen_t    target_o
);

    typedef enum logic [1:0] {IDLE, DIV_REQ, DIV_DROP} ctrl_state_e;

    ctrl_state_e state_q;
    div_cmd_t    div_cmd_q;
    div_fn_e     dv_fn;
    logic        accept;
    logic        is_div;
    xlen_t       sel_res;

    assign accept    = issue_valid_i && !busy_o;
    assign is_div    = (op_i.opcode == OP_DIV);
    assign dv_fn     = div_fn_e'(op_i.funct);
    assign div_req_o = (state_q == DIV_REQ);
    assign div_cmd_o = div_cmd_q;

    always_comb begin
        case (op_i.opcode)
            OP_JAL, OP_JALR, OP_AUIPC: sel_res = link_i;
            OP_BRANCH:                 sel_res = target_i;
            default:                   sel_res = alu_res_i;
        endcase
    end

    always_ff @(posedge clk_sys_i) begin
        if (accept && is_div) begin
            div_cmd_q <= '{dividend:  rs1_i,
                           divisor:   rs2_i,
                           is_signed: (dv_fn == DV_DIV) || (dv_fn == DV_REM),
                           want_rem:  (dv_fn == DV_REM) || (dv_fn == DV_REMU),
                           trunc:     op_i.trunc};
        end
    end

    always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q        <= IDLE;
            busy_o         <= 1'b0;
            result_valid_o <= 1'b0;
            result_o       <= '0;
            jump_o         <= 1'b0;
            target_o       <= '0;
        end else begin
            result_valid_o <= 1'b0;
            if (state_q == DIV_REQ) begin
                if (div_ack_i) begin // capture, then drop req
                    result_o       <= div_res_i;
                    jump_o         <= 1'b0;
                    result_valid_o <= 1'b1;
                    busy_o         <= 1'b0;
                    state_q        <= DIV_DROP;
                end
            end else begin
                if (state_q == DIV_DROP && !div_ack_i) state_q <= IDLE;
                if (accept && is_div) begin
                    busy_o  <= 1'b1;
                    state_q <= DIV_REQ; // ack is low again by now
                end else if (accept) begin
                    result_o       <= sel_res;
                    jump_o         <= take_i;
                    target_o       <= target_i;
                    result_valid_o <= 1'b1;
                end
            end
        end
    end

    req_held_a: assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
        div_req_o && !div_ack_i |=> div_req_o);

    div_busy_a: assert property (@(posedge clk_sys_i) disable iff (!arst_n_i)
        state_q == DIV_REQ |-> busy_o && !result_valid_o);

endmodule

// File: rtl/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; (
    input  logic   clk_sys_i,
    input  logic   arst_n_i,
    input  logic   issue_valid_i,
    input  ex_op_t op_i,
    input  xlen_t  rs1_i,
    input  xlen_t  rs2_i,
    input  xlen_t  imm_i,
    input  xlen_t  pc_i,
    output logic   busy_o,
    output logic   result_valid_o,
    output xlen_t  result_o,
    output logic   jump_o,
    output xlen_t  target_o
);

    xlen_t    alu_res;
    logic     br_take;
    xlen_t    br_target;
    xlen_t    br_link;
    logic     div_req;
    div_cmd_t div_cmd;
    logic     div_ack;
    xlen_t    div_res;

    int_alu u_int_alu (
        .op_i      (op_i),
        .rs1_i     (rs1_i),
        .rs2_i     (rs2_i),
        .imm_i     (imm_i),
        .alu_res_o (alu_res)
    );

    branch_unit u_branch_unit (
        .op_i     (op_i),
        .rs1_i    (rs1_i),
        .rs2_i    (rs2_i),
        .imm_i    (imm_i),
        .pc_i     (pc_i),
        .take_o   (br_take),
        .target_o (br_target),
        .link_o   (br_link)
    );

    ex_ctrl u_ex_ctrl (
        .clk_sys_i      (clk_sys_i),
        .arst_n_i       (arst_n_i),
        .issue_valid_i  (issue_valid_i),
        .op_i           (op_i),
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .alu_res_i      (alu_res),
        .link_i         (br_link),
        .target_i       (br_target),
        .take_i         (br_take),
        .div_req_o      (div_req),
        .div_cmd_o      (div_cmd),
        .div_ack_i      (div_ack),
        .div_res_i      (div_res),
        .busy_o         (busy_o),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .jump_o         (jump_o),
        .target_o       (target_o)
    );

    serial_divider u_serial_divider (
        .clk_sys_i (clk_sys_i),
        .arst_n_i  (arst_n_i),
        .div_req_i (div_req),
        .div_cmd_i (div_cmd),
        .div_ack_o (div_ack),
        .div_res_o (div_res)
    );

endmodule

// File: sim/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

function automatic xlen_t sign_ext_word(xlen_t v);
    return {{HALF{v[HALF-1]}}, v[HALF-1:0]};
endfunction

function automatic xlen_t alu_expected(ex_op_t op, xlen_t a, xlen_t b);
    xlen_t       r;
    int unsigned sh;
    if (op.trunc) begin
        a = sign_ext_word(a);
        b = sign_ext_word(b);
    end
    sh = op.trunc ? b[4:0] : b[5:0];
    case (alu_fn_e'(op.funct))
        FN_ADD:  r = a + b;
        FN_SUB:  r = a - b;
        FN_SLL:  r = a << sh;
        FN_SLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        FN_SLTU: r = (a < b) ? 64'd1 : 64'd0;
        FN_XOR:  r = a ^ b;
        FN_SRL:  r = op.trunc ? {{HALF{1'b0}}, a[HALF-1:0]} >> sh : a >> sh;
        FN_SRA:  r = $signed(a) >>> sh;
        FN_OR:   r = a | b;
        FN_AND:  r = a & b;
        default: r = '0;
    endcase
    return op.trunc ? sign_ext_word(r) : r;
endfunction

function automatic logic branch_taken(funct_t fn, xlen_t a, xlen_t b);
    case (br_fn_e'(fn))
        BR_EQ:   return a == b;
        BR_NE:   return a != b;
        BR_LT:   return $signed(a) < $signed(b);
        BR_GE:   return $signed(a) >= $signed(b);
        BR_LTU:  return a < b;
        BR_GEU:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

function automatic void ctrl_expected(input ex_op_t op, input xlen_t a, input xlen_t b,
                                      input xlen_t imm, input xlen_t pc, output xlen_t res,
                                      output logic jmp, output xlen_t tgt);
    tgt = pc + imm;
    jmp = 1'b0;
    case (op.opcode)
        OP_REG:   res = alu_expected(op, a, b);
        OP_IMM:   res = alu_expected(op, a, imm);
        OP_LUI:   res = imm;
        OP_AUIPC: res = pc + imm;
        OP_BRANCH: begin
            jmp = branch_taken(op.funct, a, b);
            res = tgt;
        end
        OP_JAL: begin
            jmp = 1'b1;
            res = pc + 64'd4;
        end
        OP_JALR: begin
            jmp = 1'b1;
            res = pc + 64'd4;
            tgt = (a + imm) & ~64'd1;
        end
        default:  res = '0;
    endcase
endfunction

function automatic xlen_t div_expected(funct_t fn, logic trunc, xlen_t a, xlen_t b);
    logic  sgn;
    xlen_t min_neg;
    xlen_t q;
    xlen_t r;
    sgn     = (fn == DV_DIV) || (fn == DV_REM);
    min_neg = {1'b1, {(XLEN-1){1'b0}}};
    if (trunc) begin
        a       = sgn ? sign_ext_word(a) : {{HALF{1'b0}}, a[HALF-1:0]};
        b       = sgn ? sign_ext_word(b) : {{HALF{1'b0}}, b[HALF-1:0]};
        min_neg = sign_ext_word(64'h8000_0000);
    end
    if (b == '0) begin
        q = '1;
        r = a;
    end else if (sgn && a == min_neg && b == '1) begin
        q = a;
        r = '0;
    end else if (sgn) begin
        q = $signed(a) / $signed(b);
        r = $signed(a) % $signed(b);
    end else begin
        q = a / b;
        r = a % b;
    end
    q = ((fn == DV_REM) || (fn == DV_REMU)) ? r : q;
    return trunc ? sign_ext_word(q) : q;
endfunction

`endif

// File: sim/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage import ex_pkg::*; ();

    localparam int    N_OPS        = 320;
    localparam int    WAIT_CYC     = XLEN + 10;
    localparam int    WATCHDOG_CYC = N_OPS * WAIT_CYC + 20;
    localparam xlen_t MSB          = {1'b1, {(XLEN-1){1'b0}}};

    logic        clk_sys;
    logic        arst_n;
    logic        issue_valid;
    ex_op_t      op;
    xlen_t       rs1;
    xlen_t       rs2;
    xlen_t       imm;
    xlen_t       pc;
    logic        busy;
    logic        result_valid;
    xlen_t       result;
    logic        jump;
    xlen_t       target;
    int          err_cnt;
    int          chk_cnt;
    logic [31:0] lcg_state;

    `include "ex_ref_model.svh"

    ex_stage dut (
        .clk_sys_i      (clk_sys),
        .arst_n_i       (arst_n),
        .issue_valid_i  (issue_valid),
        .op_i           (op),
        .rs1_i          (rs1),
        .rs2_i          (rs2),
        .imm_i          (imm),
        .pc_i           (pc),
        .busy_o         (busy),
        .result_valid_o (result_valid),
        .result_o       (result),
        .jump_o         (jump),
        .target_o       (target)
    );

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic xlen_t rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi, lo};
    endfunction

    function automatic ex_op_t mk_op(ex_opcode_e oc, funct_t fn, logic tr);
        return '{opcode: oc, funct: fn, trunc: tr};
    endfunction

    task automatic check(string name, xlen_t exp, xlen_t act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic report(string name, int e0);
        $display("%-12s done, %0d errors", name, err_cnt - e0);
    endtask

    // returns on the edge where the instruction is taken
    task automatic issue_op(ex_op_t o, xlen_t a, xlen_t b, xlen_t im, xlen_t p);
        issue_valid <= 1'b1;
        op          <= o;
        rs1         <= a;
        rs2         <= b;
        imm         <= im;
        pc          <= p;
        @(posedge clk_sys);
        while (busy) @(posedge clk_sys);
        issue_valid <= 1'b0;
    endtask

    task automatic wait_result(string name, logic is_div, output int cycles);
        cycles = 0;
        do begin
            @(posedge clk_sys);
            cycles++;
            if (is_div && !result_valid && !busy) begin
                err_cnt++;
                $display("%s: busy_o fell before the divide result", name);
            end
        end while (!result_valid && cycles < WAIT_CYC);
        if (!result_valid) begin
            err_cnt++;
            $display("%s: no result_valid_o within %0d cycles", name, WAIT_CYC);
        end
    endtask

    task automatic single_op(string name, ex_op_t o, xlen_t a, xlen_t b, xlen_t im, xlen_t p);
        xlen_t exp_res;
        logic  exp_jmp;
        xlen_t exp_tgt;
        int    cycles;
        ctrl_expected(o, a, b, im, p, exp_res, exp_jmp, exp_tgt);
        issue_op(o, a, b, im, p);
        wait_result(name, 1'b0, cycles);
        check({name, " latency"}, 64'd1, xlen_t'(cycles));
        check(name, exp_res, result);
        check({name, " jump"}, xlen_t'(exp_jmp), xlen_t'(jump));
        if (o.opcode inside {OP_BRANCH, OP_JAL, OP_JALR}) begin
            check({name, " target"}, exp_tgt, target);
        end
    endtask

    task automatic divide_op(string name, funct_t fn, logic tr, xlen_t a, xlen_t b);
        xlen_t exp_res;
        int    cycles;
        exp_res = div_expected(fn, tr, a, b);
        issue_op(mk_op(OP_DIV, fn, tr), a, b, '0, '0);
        wait_result(name, 1'b1, cycles);
        check(name, exp_res, result);
        check({name, " jump"}, '0, xlen_t'(jump));
    endtask

    task automatic reset_values();
        int e0;
        e0 = err_cnt;
        repeat (10) @(posedge clk_sys);
        arst_n <= 1'b1;
        @(posedge clk_sys);
        check("reset busy", '0, xlen_t'(busy));
        check("reset valid", '0, xlen_t'(result_valid));
        check("reset jump", '0, xlen_t'(jump));
        check("reset result", '0, result);
        check("reset target", '0, target);
        report("reset", e0);
    endtask

    task automatic alu_cases();
        alu_fn_e fn;
        xlen_t   a;
        xlen_t   b;
        string   nm;
        int      e0;
        e0 = err_cnt;
        fn = fn.first();
        do begin
            for (int tr = 0; tr < 2; tr++) begin
                for (int k = 0; k < 4; k++) begin
                    a  = rand64();
                    b  = rand64();
                    nm = $sformatf("alu %s w%0d", fn.name(), tr);
                    single_op({nm, " reg"}, mk_op(OP_REG, fn, tr[0]), a, b, '0, '0);
                    if (fn != FN_SUB) begin // no subi
                        single_op({nm, " imm"}, mk_op(OP_IMM, fn, tr[0]), a, rand64(), b, '0);
                    end
                end
            end
            fn = fn.next();
        end while (fn != fn.first());
        a = rand64();
        single_op("sltu msb a", mk_op(OP_REG, FN_SLTU, 1'b0), MSB, 64'd1, '0, '0);
        single_op("sltu msb b", mk_op(OP_REG, FN_SLTU, 1'b0), 64'd1, '1, '0, '0);
        single_op("slt msb a", mk_op(OP_REG, FN_SLT, 1'b0), MSB, 64'd1, '0, '0);
        single_op("sltu equal", mk_op(OP_REG, FN_SLTU, 1'b0), a, a, '0, '0);
        report("alu", e0);
    endtask

    task automatic branch_cases();
        br_fn_e fn;
        xlen_t  a;
        xlen_t  b;
        string  nm;
        int     e0;
        e0 = err_cnt;
        fn = fn.first();
        do begin
            a  = rand64();
            b  = rand64();
            nm = $sformatf("branch %s", fn.name());
            single_op({nm, " rand"}, mk_op(OP_BRANCH, fn, 1'b0), a, b, rand64(), rand64());
            single_op({nm, " equal"}, mk_op(OP_BRANCH, fn, 1'b0), a, a, rand64(), rand64());
            single_op({nm, " sign"}, mk_op(OP_BRANCH, fn, 1'b0), a | MSB, b & ~MSB,
                      rand64(), rand64());
            fn = fn.next();
        end while (fn != fn.first());
        report("branch", e0);
    endtask

    task automatic jump_cases();
        int e0;
        e0 = err_cnt;
        for (int k = 0; k < 4; k++) begin
            single_op("jal", mk_op(OP_JAL, '0, 1'b0), rand64(), rand64(), rand64(), rand64());
            single_op("jalr", mk_op(OP_JALR, '0, 1'b0), rand64(), rand64(), rand64(), rand64());
            single_op("lui", mk_op(OP_LUI, '0, 1'b0), rand64(), rand64(), rand64(), rand64());
            single_op("auipc", mk_op(OP_AUIPC, '0, 1'b0), rand64(), rand64(), rand64(),
                      rand64());
        end
        report("jump", e0);
    endtask

    task automatic divide_cases();
        div_fn_e     fn;
        logic [31:0] sh;
        xlen_t       b;
        string       nm;
        int          e0;
        e0 = err_cnt;
        fn = fn.first();
        do begin
            for (int tr = 0; tr < 2; tr++) begin
                nm = $sformatf("div %s w%0d", fn.name(), tr);
                for (int k = 0; k < 4; k++) begin
                    sh = lcg_next();
                    b  = rand64() >> sh[5:0]; // mix of divisor sizes
                    divide_op(nm, fn, tr[0], rand64(), b);
                end
                b = tr ? {lcg_next(), 32'h0} : '0; // upper half ignored for W
                divide_op({nm, " by zero"}, fn, tr[0], rand64(), b);
            end
            fn = fn.next();
        end while (fn != fn.first());
        divide_op("div overflow", DV_DIV, 1'b0, MSB, '1);
        divide_op("rem overflow", DV_REM, 1'b0, MSB, '1);
        divide_op("divw overflow", DV_DIV, 1'b1, {lcg_next(), 32'h8000_0000},
                  {lcg_next(), 32'hffff_ffff});
        divide_op("remw overflow", DV_REM, 1'b1, {lcg_next(), 32'h8000_0000},
                  {lcg_next(), 32'hffff_ffff});
        report("div", e0);
    endtask

    task automatic held_issue();
        ex_op_t aop;
        xlen_t  a;
        xlen_t  b;
        xlen_t  c;
        xlen_t  d;
        xlen_t  exp_div;
        xlen_t  exp_add;
        logic   got_div;
        int     cycles;
        int     e0;
        e0      = err_cnt;
        aop     = mk_op(OP_REG, FN_ADD, 1'b0);
        a       = rand64();
        b       = {32'h0, lcg_next()} | 64'd1;
        c       = rand64();
        d       = rand64();
        exp_div = div_expected(DV_DIVU, 1'b0, a, b);
        exp_add = alu_expected(aop, c, d);
        issue_op(mk_op(OP_DIV, DV_DIVU, 1'b0), a, b, '0, '0);
        issue_valid <= 1'b1; // held while the divider runs
        op          <= aop;
        rs1         <= c;
        rs2         <= d;
        got_div = 1'b0;
        cycles  = 0;
        do begin
            @(posedge clk_sys);
            cycles++;
            if (result_valid) begin
                got_div = 1'b1;
                check("backpressure div", exp_div, result);
            end
        end while (busy && cycles < WAIT_CYC);
        issue_valid <= 1'b0;
        check("backpressure order", 64'd1, xlen_t'(got_div));
        wait_result("backpressure add", 1'b0, cycles);
        check("backpressure add latency", 64'd1, xlen_t'(cycles));
        check("backpressure add", exp_add, result);
        report("backpressure", e0);
    endtask

    initial begin
        arst_n      <= 1'b0;
        issue_valid <= 1'b0;
        op          <= '0;
        rs1         <= '0;
        rs2         <= '0;
        imm         <= '0;
        pc          <= '0;
        lcg_state = 32'h4d45ff94;
        err_cnt   = 0;
        chk_cnt   = 0;
        reset_values();
        alu_cases();
        branch_cases();
        jump_cases();
        divide_cases();
        held_issue();
        $display("%0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk_sys);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYC);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: files.f
+incdir+sim
common/ex_pkg.sv
alu/int_alu.sv
alu/branch_unit.sv
div/serial_divider.sv
rtl/ex_ctrl.sv
rtl/ex_stage.sv
sim/tb_ex_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
